//--- Bender.yml
package:
  name: sa_systolic

sources:
  - src/sa_arith_pkg.sv
  - src/sa_ctrl_pkg.sv
  - src/skew_feeder.sv
  - src/mac_pe_packed.sv
  - src/systolic_array.sv
  - src/channel_drain.sv
  - src/sa_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_sa_top.sv

//--- project.f
+incdir+testbench
src/sa_arith_pkg.sv
src/sa_ctrl_pkg.sv
src/skew_feeder.sv
src/mac_pe_packed.sv
src/systolic_array.sv
src/channel_drain.sv
src/sa_top.sv
testbench/tb_sa_top.sv

//--- src/channel_drain.sv
module channel_drain
    import sa_arith_pkg::*, sa_ctrl_pkg::*;
#(
    parameter int row_num    = 4,
    parameter int column_num = 4
) (
    input  logic                                  clk,
    input  logic                                  channel_out_reset,
    input  logic                                  channel_out_en,
    input  pe_out_t [row_num-1:0][column_num-1:0] pe_results,
    output pe_out_t [column_num-1:0]              out
);

    localparam int row_w = (row_num > 1) ? $clog2(row_num) : 1;

    drain_state_t     state;
    logic [row_w-1:0] row_cnt;

    //////////////////////////////////////////////////////////////////////
    // row stepping
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            state   <= drain_parked;
            row_cnt <= '0;
        end else if (channel_out_en) begin
            case (state)
                // first step selects row 0
                drain_parked: begin
                    state   <= drain_draining;
                    row_cnt <= '0;
                end
                drain_draining: begin
                    if (row_cnt == row_w'(row_num - 1)) begin
                        state   <= drain_parked;
                        row_cnt <= '0;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                default: state <= drain_parked;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output select
    //////////////////////////////////////////////////////////////////////

    // one row is one output channel
    always_comb begin
        if (state == drain_draining) begin
            out = pe_results[row_cnt];
        end else begin
            out = '0;
        end
    end

endmodule

//--- src/mac_pe_packed.sv
module mac_pe_packed
    import sa_arith_pkg::*;
(
    input  logic       clk,
    input  logic       channel_out_reset,
    input  logic       en,
    input  logic       acc_clear,
    input  weight_t    left,
    input  packed_op_t up,
    output weight_t    right,
    output packed_op_t bottom,
    output pe_out_t    result
);

    packed_prod_t prod;
    pixel_prod_t  prod_lo;
    pixel_prod_t  prod_hi;
    acc_t         acc_lo;
    acc_t         acc_hi;

    //////////////////////////////////////////////////////////////////////
    // packed multiply and unpack
    //////////////////////////////////////////////////////////////////////

    // w * (ph << 16 + pl) in one multiplier
    assign prod    = left * up;
    assign prod_lo = prod[15:0];

    // a negative low product borrows one from the upper field
    assign prod_hi = prod[31:16] + pixel_prod_t'(prod[15]);

    //////////////////////////////////////////////////////////////////////
    // accumulate and pass through
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (channel_out_reset || acc_clear) begin
            acc_lo <= '0;
            acc_hi <= '0;
        end else if (en) begin
            acc_lo <= acc_lo + {{(acc_w-pair_w){prod_lo[pair_w-1]}}, prod_lo};
            acc_hi <= acc_hi + {{(acc_w-pair_w){prod_hi[pair_w-1]}}, prod_hi};
        end
    end

    // neighbours only move when the array is enabled
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            right  <= '0;
            bottom <= '0;
        end else if (en) begin
            right  <= left;
            bottom <= up;
        end
    end

    assign result = {acc_hi, acc_lo};

endmodule

//--- src/sa_arith_pkg.sv
package sa_arith_pkg;

    //////////////////////////////////////////////////////////////////////
    // data widths
    //////////////////////////////////////////////////////////////////////

    localparam int weight_w = 8;
    localparam int pixel_w  = 8;
    localparam int pair_w   = 2 * pixel_w;
    localparam int op_w     = 24;
    // 16 bits of product plus 8 of headroom
    localparam int acc_w    = 24;

    // signed operands
    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic signed [pixel_w-1:0]  pixel_t;

    // one feature-map lane with the high pixel in the upper byte
    typedef logic [pair_w-1:0] pixel_pair_t;

    // high pixel << 16 plus sign-extended low pixel
    typedef logic signed [op_w-1:0] packed_op_t;

    // weight times packed operand
    typedef logic signed [weight_w+op_w-1:0] packed_prod_t;

    // one pixel's product after unpacking
    typedef logic signed [pair_w-1:0] pixel_prod_t;

    // accumulators wrap modulo 2^24
    typedef logic [acc_w-1:0] acc_t;

    // high accumulator above low accumulator
    typedef logic [2*acc_w-1:0] pe_out_t;

endpackage

//--- src/sa_ctrl_pkg.sv
package sa_ctrl_pkg;

    // feeder states for waiting, taking samples and letting the skew run out
    typedef enum logic [1:0] {
        feed_idle   = 2'd0,
        feed_stream = 2'd1,
        feed_flush  = 2'd2
    } feed_state_t;

    // drain keeps out at zero or walks the rows
    typedef enum logic {
        drain_parked   = 1'b0,
        drain_draining = 1'b1
    } drain_state_t;

endpackage

//--- src/sa_top.sv
module sa_top
    import sa_arith_pkg::*;
#(
    parameter int row_num    = 4,
    parameter int column_num = 4
) (
    input  logic                         clk,
    input  logic                         channel_out_reset,
    input  logic                         in_valid,
    input  logic                         acc_clear,
    input  weight_t     [row_num-1:0]    row_in,
    input  pixel_pair_t [column_num-1:0] column_in,
    input  logic                         channel_out_en,
    output logic                         drain_ready,
    output pe_out_t     [column_num-1:0] out
);

    weight_t    [row_num-1:0]                 skew_row;
    packed_op_t [column_num-1:0]              skew_col;
    logic                                     mac_en;
    logic                                     acc_clear_o;
    pe_out_t    [row_num-1:0][column_num-1:0] pe_results;

    // producer that skews and packs
    skew_feeder #(
        .row_num    (row_num),
        .column_num (column_num)
    ) skew_feeder_i (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .in_valid          (in_valid),
        .acc_clear         (acc_clear),
        .row_in            (row_in),
        .column_in         (column_in),
        .skew_row          (skew_row),
        .skew_col          (skew_col),
        .mac_en            (mac_en),
        .acc_clear_o       (acc_clear_o),
        .drain_ready       (drain_ready)
    );

    // accumulating grid
    systolic_array #(
        .row_num    (row_num),
        .column_num (column_num)
    ) systolic_array_i (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .mac_en            (mac_en),
        .acc_clear         (acc_clear_o),
        .skew_row          (skew_row),
        .skew_col          (skew_col),
        .pe_results        (pe_results)
    );

    // consumer with one channel row per step
    channel_drain #(
        .row_num    (row_num),
        .column_num (column_num)
    ) channel_drain_i (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .pe_results        (pe_results),
        .out               (out)
    );

endmodule

//--- src/skew_feeder.sv
module skew_feeder
    import sa_arith_pkg::*, sa_ctrl_pkg::*;
#(
    parameter int row_num    = 4,
    parameter int column_num = 4
) (
    input  logic                             clk,
    input  logic                             channel_out_reset,
    input  logic                             in_valid,
    input  logic                             acc_clear,
    input  weight_t     [row_num-1:0]        row_in,
    input  pixel_pair_t [column_num-1:0]     column_in,
    output weight_t     [row_num-1:0]        skew_row,
    output packed_op_t  [column_num-1:0]     skew_col,
    output logic                             mac_en,
    output logic                             acc_clear_o,
    output logic                             drain_ready
);

    localparam int depth      = (row_num > column_num) ? row_num : column_num;
    // cycles spent in flush before the far corner has taken the last sample
    localparam int flush_last = row_num + column_num - 2;
    localparam int cnt_w      = $clog2(row_num + column_num);

    feed_state_t      state;
    logic [cnt_w-1:0] flush_cnt;
    logic             flush_done;
    logic [depth-1:0] valid_line;
    packed_op_t       packed_in [column_num];

    //////////////////////////////////////////////////////////////////////
    // operand packing and delay lines
    //////////////////////////////////////////////////////////////////////

    // high pixel into bits 23:16, low pixel sign-extended below it
    always_comb begin
        for (int j = 0; j < column_num; j++) begin
            packed_in[j] = {column_in[j][pair_w-1:pixel_w], 16'b0}
                         + {{16{column_in[j][pixel_w-1]}}, column_in[j][pixel_w-1:0]};
        end
    end

    // valid bit k is in_valid delayed k+1 cycles
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            valid_line <= '0;
        end else begin
            valid_line[0] <= in_valid;
            for (int k = 1; k < depth; k++) begin
                valid_line[k] <= valid_line[k-1];
            end
        end
    end

    // row i sees i+1 stages
    for (genvar i = 0; i < row_num; i++) begin : g_row
        weight_t w_line [i+1];

        always_ff @(posedge clk) begin
            w_line[0] <= row_in[i];
            for (int k = 1; k <= i; k++) begin
                w_line[k] <= w_line[k-1];
            end
        end

        assign skew_row[i] = valid_line[i] ? w_line[i] : '0;
    end

    // column j sees j+1 stages
    for (genvar j = 0; j < column_num; j++) begin : g_col
        packed_op_t p_line [j+1];

        always_ff @(posedge clk) begin
            p_line[0] <= packed_in[j];
            for (int k = 1; k <= j; k++) begin
                p_line[k] <= p_line[k-1];
            end
        end

        assign skew_col[j] = valid_line[j] ? p_line[j] : '0;
    end

    //////////////////////////////////////////////////////////////////////
    // stream / flush control
    //////////////////////////////////////////////////////////////////////

    assign flush_done = (state == feed_flush) && !in_valid
                     && (flush_cnt == cnt_w'(flush_last));

    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            state       <= feed_idle;
            flush_cnt   <= '0;
            drain_ready <= 1'b0;
        end else begin
            case (state)
                feed_idle: begin
                    if (in_valid) state <= feed_stream;
                end
                feed_stream: begin
                    if (!in_valid) begin
                        state     <= feed_flush;
                        flush_cnt <= cnt_w'(1);
                    end
                end
                feed_flush: begin
                    if (in_valid) begin
                        state <= feed_stream;
                    end else if (flush_done) begin
                        state <= feed_idle;
                    end else begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end
                default: state <= feed_idle;
            endcase

            // new data or a clear makes the results stale
            if (in_valid || acc_clear) begin
                drain_ready <= 1'b0;
            end else if (flush_done) begin
                drain_ready <= 1'b1;
            end
        end
    end

    assign mac_en      = (state != feed_idle);
    assign acc_clear_o = acc_clear;

endmodule

//--- src/systolic_array.sv
module systolic_array
    import sa_arith_pkg::*;
#(
    parameter int row_num    = 4,
    parameter int column_num = 4
) (
    input  logic                                     clk,
    input  logic                                     channel_out_reset,
    input  logic                                     mac_en,
    input  logic                                     acc_clear,
    input  weight_t    [row_num-1:0]                 skew_row,
    input  packed_op_t [column_num-1:0]              skew_col,
    output pe_out_t    [row_num-1:0][column_num-1:0] pe_results
);

    //////////////////////////////////////////////////////////////////////
    // neighbour wiring
    //////////////////////////////////////////////////////////////////////

    // h_bus[i][j] is the left input of element (i, j)
    weight_t    h_bus [row_num][column_num+1];
    // v_bus[i][j] is the up input of element (i, j)
    packed_op_t v_bus [row_num+1][column_num];

    // weights enter at column 0
    for (genvar i = 0; i < row_num; i++) begin : g_west
        assign h_bus[i][0] = skew_row[i];
    end

    // packed pixels enter at row 0
    for (genvar j = 0; j < column_num; j++) begin : g_north
        assign v_bus[0][j] = skew_col[j];
    end

    //////////////////////////////////////////////////////////////////////
    // element grid
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < row_num; i++) begin : g_pe_row
        for (genvar j = 0; j < column_num; j++) begin : g_pe_col
            mac_pe_packed pe_i (
                .clk               (clk),
                .channel_out_reset (channel_out_reset),
                .en                (mac_en),
                .acc_clear         (acc_clear),
                .left              (h_bus[i][j]),
                .up                (v_bus[i][j]),
                .right             (h_bus[i][j+1]),
                .bottom            (v_bus[i+1][j]),
                .result            (pe_results[i][j])
            );
        end
    end

endmodule

//--- testbench/tb_sa_util.svh
`ifndef TB_SA_UTIL_SVH
`define TB_SA_UTIL_SVH

// fibonacci lfsr with taps 16 14 13 11
logic [15:0] lfsr_state = 16'd56720;

function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

// n fresh bits with one step each
function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[6:0], lfsr_step()};
    end
    return v;
endfunction

// element (r, j) sums weight r times each pixel of lane j since the last clear
function automatic pe_out_t ref_result(input int r, input int j);
    acc_t   hi;
    acc_t   lo;
    pixel_t ph;
    pixel_t pl;
    int     w;
    int     p;
    hi = '0;
    lo = '0;
    for (int s = 0; s < model_cnt; s++) begin
        w  = model_w[s][r];
        ph = model_p[s][j][15:8];
        pl = model_p[s][j][7:0];
        p  = w * ph;
        hi = hi + p[23:0];
        p  = w * pl;
        lo = lo + p[23:0];
    end
    return {hi, lo};
endfunction

task automatic check_out(input string name, input pe_out_t exp, input pe_out_t act);
    checks++;
    if (act !== exp) begin
        out_errors++;
        $display("Error %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        flag_errors++;
        $display("Error %s drain_ready: expected %b, actual %b", name, exp, act);
    end
endtask

`endif

//--- testbench/tb_sa_top.sv
module tb_sa_top
    import sa_arith_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int row_num     = 4;
    localparam int column_num  = 4;
    localparam int n_rand      = 8;
    localparam int known_idx   = n_rand;
    localparam int max_samples = 2 * n_rand + 1;
    localparam int wait_limit  = 4 * (row_num + column_num);
    // worst case per test is two gapped passes with flush wait and drain
    localparam int run_limit   = 40 + 12 * (4 * n_rand + wait_limit + 2 * row_num + 4);

    logic clk;
    logic channel_out_reset;
    logic in_valid;
    logic acc_clear;
    logic channel_out_en;
    logic drain_ready;
    weight_t     [row_num-1:0]    row_in;
    pixel_pair_t [column_num-1:0] column_in;
    pe_out_t     [column_num-1:0] out;

    weight_t     stim_w  [n_rand+1][row_num];
    pixel_pair_t stim_p  [n_rand+1][column_num];
    weight_t     model_w [max_samples][row_num];
    pixel_pair_t model_p [max_samples][column_num];
    int          model_cnt    = 0;
    int          checks       = 0;
    int          out_errors   = 0;
    int          flag_errors  = 0;
    int          other_errors = 0;
    int          cycles       = 0;
    // row expected on out or -1 while parked
    int          drain_row    = -1;
    logic        check_armed  = 1'b0;
    string       test_name    = "reset";

    `include "tb_sa_util.svh"

    sa_top sa_top_i (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .in_valid          (in_valid),
        .acc_clear         (acc_clear),
        .row_in            (row_in),
        .column_in         (column_in),
        .channel_out_en    (channel_out_en),
        .drain_ready       (drain_ready),
        .out               (out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= run_limit) begin
            $display("timeout: tests still running after %0d cycles", run_limit);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output checker at mid cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (check_armed) begin
            for (int j = 0; j < column_num; j++) begin
                if (drain_row < 0) begin
                    check_out($sformatf("%s parked col %0d", test_name, j), '0, out[j]);
                end else begin
                    check_out($sformatf("%s row %0d col %0d", test_name, drain_row, j),
                              ref_result(drain_row, j), out[j]);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks entered 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic stream_sample(input int s);
        in_valid = 1'b1;
        for (int i = 0; i < row_num; i++) begin
            row_in[i]                = stim_w[s][i];
            model_w[model_cnt][i]    = stim_w[s][i];
        end
        for (int j = 0; j < column_num; j++) begin
            column_in[j]             = stim_p[s][j];
            model_p[model_cnt][j]    = stim_p[s][j];
        end
        model_cnt++;
        @(posedge clk);
        #1;
        in_valid  = 1'b0;
        row_in    = '0;
        column_in = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic clear_acc();
        acc_clear = 1'b1;
        @(posedge clk);
        #1;
        acc_clear = 1'b0;
        model_cnt = 0;
    endtask

    task automatic apply_reset();
        channel_out_reset = 1'b1;
        @(posedge clk);
        #1;
        drain_row = -1;
        model_cnt = 0;
        idle(4);
        channel_out_reset = 1'b0;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (drain_ready !== 1'b1 && n < wait_limit) begin
            idle(1);
            n++;
        end
        if (drain_ready !== 1'b1) begin
            other_errors++;
            $display("%s: drain_ready stayed low for %0d cycles", test_name, wait_limit);
        end
    endtask

    task automatic step_drain(input int next_row);
        channel_out_en = 1'b1;
        idle(1);
        channel_out_en = 1'b0;
        drain_row      = next_row;
        idle(1);
    endtask

    // every row in order and then the step that parks
    task automatic drain_all();
        for (int r = 0; r < row_num; r++) begin
            step_drain(r);
        end
        step_drain(-1);
    endtask

    initial begin
        channel_out_reset = 1'b1;
        in_valid          = 1'b0;
        acc_clear         = 1'b0;
        channel_out_en    = 1'b0;
        row_in            = '0;
        column_in         = '0;
        apply_reset();
        check_armed = 1'b1;

        test_name = "idle";
        for (int k = 0; k < 20; k++) begin
            check_flag(test_name, 1'b0, drain_ready);
            idle(1);
        end

        // weights 3 -2 5 -7 and lanes (4,-3) (-5,6) (7,-8) (2,-128)
        test_name = "known";
        stim_w[known_idx] = '{8'sh03, 8'shfe, 8'sh05, 8'shf9};
        stim_p[known_idx] = '{16'h04fd, 16'hfb06, 16'h07f8, 16'h0280};
        stream_sample(known_idx);
        wait_ready();
        drain_all();

        // high pixel kept above -128 so the packed operand fits 24 bits
        for (int s = 0; s < n_rand; s++) begin
            for (int i = 0; i < row_num; i++) begin
                stim_w[s][i] = take_bits(8);
            end
            for (int j = 0; j < column_num; j++) begin
                stim_p[s][j][15:8] = take_bits(8);
                while (stim_p[s][j][15:8] == 8'h80) begin
                    stim_p[s][j][15:8] = take_bits(8);
                end
                stim_p[s][j][7:0] = take_bits(8);
            end
        end

        test_name = "burst";
        clear_acc();
        for (int s = 0; s < n_rand; s++) begin
            stream_sample(s);
        end
        wait_ready();
        drain_all();

        test_name = "gaps";
        clear_acc();
        for (int s = 0; s < n_rand; s++) begin
            stream_sample(s);
            idle(take_bits(2));
        end
        wait_ready();
        drain_all();

        // no clear so the model holds both passes
        test_name = "accumulate";
        for (int s = 0; s < n_rand; s++) begin
            stream_sample(s);
        end
        wait_ready();
        drain_all();

        test_name = "after clear";
        clear_acc();
        check_flag(test_name, 1'b0, drain_ready);
        stream_sample(known_idx);
        for (int s = n_rand / 2; s < n_rand; s++) begin
            stream_sample(s);
        end
        wait_ready();
        drain_all();

        test_name = "reset in drain";
        step_drain(0);
        step_drain(1);
        apply_reset();
        check_flag(test_name, 1'b0, drain_ready);
        idle(3);
        step_drain(0);

        $display("checks %0d, out errors %0d, flag errors %0d, other errors %0d",
                 checks, out_errors, flag_errors, other_errors);
        if (out_errors + flag_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
